//--- gat_debug_top.f
+incdir+.
dbg_pkg.sv
dbg_apb_pkg.sv
dbg_ctrl.sv
stage_flag_tracker.sv
stage_event_counter.sv
sppe_capture.sv
feat_write_monitor.sv
gat_debug_top.sv
tb_clk_gen.sv
tb_gat_debug.sv

//--- Makefile
TB_TOP := tb_gat_debug

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module gat_debug_top -f gat_debug_top.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f gat_debug_top.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- tb_gat_debug.sv
`timescale 1ns/10ps
`include "gat_debug_config.svh"

module tb_gat_debug
  import dbg_pkg::*;
  import dbg_apb_pkg::*;
();

  localparam int clk_period  = 20;
  localparam int test_cycles = 70 + 50 + 250 + 260 + 200;

  logic       clk;
  logic       rst_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  apb_data_t  pwdata;
  apb_data_t  prdata;
  logic       pready;
  logic       pslverr;
  logic       spmm_vld;
  logic       spmm_rdy;
  logic       dmvm_vld;
  logic       dmvm_rdy;
  logic       sm_vld;
  logic       sm_rdy;
  logic       aggr_vld;
  logic       aggr_rdy;
  wh_addr_t   wh_addr;
  sppe_bus_t  sppe;
  feat_addr_t feat_addr;
  logic       feat_ena;
  logic       expect_err;
  int         errors;
  int         checks;
  int         test_err_base;
  wh_addr_t   cap_a0;
  wh_addr_t   cap_a1;
  lane_sel_t  cap_sel;
  lane_data_t cap_m0;
  lane_data_t cap_m1;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_debug_top i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .psel_i           (psel),
    .penable_i        (penable),
    .pwrite_i         (pwrite),
    .paddr_i          (paddr),
    .pwdata_i         (pwdata),
    .prdata_o         (prdata),
    .pready_o         (pready),
    .pslverr_o        (pslverr),
    .spmm_vld_i       (spmm_vld),
    .spmm_rdy_i       (spmm_rdy),
    .dmvm_vld_i       (dmvm_vld),
    .dmvm_rdy_i       (dmvm_rdy),
    .sm_vld_i         (sm_vld),
    .sm_rdy_i         (sm_rdy),
    .aggr_vld_i       (aggr_vld),
    .aggr_rdy_i       (aggr_rdy),
    .wh_bram_addr_i   (wh_addr),
    .sppe_i           (sppe),
    .feat_bram_addr_i (feat_addr),
    .feat_bram_ena_i  (feat_ena)
  );

  // With zero wait states pready is high in exactly the access cycles.
  ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pready == (psel && penable))
    else begin
      $display("Mismatch pready_o at %0t: got 0x%0h, expected 0x%0h", $time, pready,
               psel && penable);
      errors++;
    end

  slverr_when_illegal: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr == (psel && penable && expect_err))
    else begin
      $display("Mismatch pslverr_o at %0t: got 0x%0h, expected 0x%0h", $time, pslverr,
               psel && penable && expect_err);
      errors++;
    end

  task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          input logic err, output apb_data_t rdata);
    int waits;
    waits = 0;
    @(negedge clk);
    psel       = 1'b1;
    penable    = 1'b0;
    pwrite     = wr;
    paddr      = addr;
    pwdata     = wdata;
    expect_err = err;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready && waits < 4) begin
      @(negedge clk);
      #1;
      waits++;
    end
    if (!pready) begin
      $display("APB transfer to offset 0x%02h never saw pready", addr);
      errors++;
    end
    rdata = prdata;
    @(negedge clk);
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    expect_err = 1'b0;
  endtask

  // An access cycle without a setup cycle is refused and writes nothing.
  task automatic access_without_setup(input apb_addr_t addr, input apb_data_t wdata);
    @(negedge clk);
    psel       = 1'b1;
    penable    = 1'b1;
    pwrite     = 1'b1;
    paddr      = addr;
    pwdata     = wdata;
    expect_err = 1'b1;
    @(negedge clk);
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    expect_err = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t ignored;
    apb_xfer(1'b1, addr, data, 1'b0, ignored);
  endtask

  task automatic check_reg(input dbg_reg_e r, input apb_data_t exp);
    apb_data_t got;
    apb_xfer(1'b0, r, '0, 1'b0, got);
    check_value(r.name(), got, exp);
  endtask

  task automatic set_stages(input stage_flags_t v, input stage_flags_t r);
    {spmm_vld, dmvm_vld, sm_vld, aggr_vld} = v;
    {spmm_rdy, dmvm_rdy, sm_rdy, aggr_rdy} = r;
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d (%s) finished with %0d errors", num, name, errors - test_err_base);
    test_err_base = errors;
  endtask

  task automatic test_reset_values();
    dbg_reg_e  r;
    apb_data_t exp;
    apb_data_t got;
    r = r.first();
    repeat (r.num()) begin
      if (r == REG_ID) begin
        exp = {8'h01, 16'h0000, 8'(`DBG_NUM_SPARSE)};
      end else if (r == REG_FEAT_LIMIT) begin
        exp = 32'(`DBG_FEAT_LIMIT_RST);
      end else begin
        exp = '0;
      end
      check_reg(r, exp);
      r = r.next();
    end
    apb_xfer(1'b0, 8'h3C, '0, 1'b1, got);
    apb_xfer(1'b0, 8'h02, '0, 1'b1, got);
    apb_xfer(1'b1, REG_FLAGS, 32'h0000_03FF, 1'b1, got);
    apb_xfer(1'b1, REG_ID, 32'hFFFF_FFFF, 1'b1, got);
    access_without_setup(REG_CAP_ADDR0, 32'h0000_1234);
    check_reg(REG_CAP_ADDR0, '0);
    check_reg(REG_FLAGS, '0);
    check_reg(REG_ID, {8'h01, 16'h0000, 8'(`DBG_NUM_SPARSE)});
    report_test(1, "reset values and ID");
  endtask

  task automatic test_sticky_flags();
    stage_flags_t v;
    stage_flags_t r;
    stage_flags_t v_acc;
    stage_flags_t r_acc;
    repeat (3) begin
      v_acc = '0;
      r_acc = '0;
      // Sparse subsets leave some flags clear in most rounds.
      repeat (3) begin
        v = stage_flags_t'($urandom & $urandom & $urandom);
        r = stage_flags_t'($urandom & $urandom & $urandom);
        @(negedge clk);
        set_stages(v, r);
        v_acc = v_acc | v;
        r_acc = r_acc | r;
      end
      @(negedge clk);
      set_stages('0, '0);
      check_reg(REG_FLAGS, 32'({v_acc, r_acc}));
      apb_write(REG_CTRL, 32'h1);
      check_reg(REG_FLAGS, '0);
    end
    report_test(2, "sticky flags");
  endtask

  task automatic test_counters();
    dbg_cnt_t     model [4];
    stage_flags_t v;
    stage_flags_t r;
    int           s;
    apb_write(REG_CTRL, 32'h2);
    for (s = 0; s < 4; s++) begin
      model[s] = '0;
    end
    repeat (200) begin
      v = stage_flags_t'($urandom);
      r = stage_flags_t'($urandom);
      @(negedge clk);
      set_stages(v, r);
      // Counter 0 belongs to SpMM in the top bit of the stage vectors.
      for (s = 0; s < 4; s++) begin
        if (v[3-s] && r[3-s]) begin
          model[s] = model[s] + 1;
        end
      end
    end
    @(negedge clk);
    set_stages('0, '0);
    for (s = 0; s < 4; s++) begin
      check_reg(dbg_reg_e'(apb_addr_t'(REG_CNT0) + apb_addr_t'(4 * s)), model[s]);
    end
    apb_write(REG_CTRL, 32'h2);
    for (s = 0; s < 4; s++) begin
      check_reg(dbg_reg_e'(apb_addr_t'(REG_CNT0) + apb_addr_t'(4 * s)), '0);
    end
    report_test(3, "handshake counters");
  endtask

  task automatic drive_capture(input int cycles, input logic enabled);
    lane_data_t lanes [`DBG_NUM_LANES];
    int         l;
    repeat (cycles) begin
      @(negedge clk);
      for (l = 0; l < `DBG_NUM_LANES; l++) begin
        lanes[l] = lane_data_t'($urandom);
        sppe[l*`DBG_LANE_W +: `DBG_LANE_W] = lanes[l];
      end
      case ($urandom_range(0, 2))
        0: wh_addr = cap_a0;
        1: wh_addr = cap_a1;
        default: wh_addr = wh_addr_t'($urandom);
      endcase
      spmm_rdy = ($urandom_range(0, 3) != 0);
      if (enabled && spmm_rdy && wh_addr == cap_a0) begin
        cap_m0 = lanes[cap_sel];
      end
      if (enabled && spmm_rdy && wh_addr == cap_a1) begin
        cap_m1 = lanes[cap_sel];
      end
    end
    @(negedge clk);
    spmm_rdy = 1'b0;
    check_reg(REG_CAP_DATA0, 32'(cap_m0));
    check_reg(REG_CAP_DATA1, 32'(cap_m1));
  endtask

  task automatic test_captures();
    cap_a0  = wh_addr_t'($urandom);
    cap_a1  = cap_a0 ^ wh_addr_t'($urandom_range(1, 16383));
    cap_sel = lane_sel_t'($urandom);
    cap_m0  = '0;
    cap_m1  = '0;
    apb_write(REG_CAP_ADDR0, 32'(cap_a0));
    apb_write(REG_CAP_ADDR1, 32'(cap_a1));
    apb_write(REG_CAP_LANE, 32'(cap_sel));
    check_reg(REG_CAP_ADDR0, 32'(cap_a0));
    check_reg(REG_CAP_ADDR1, 32'(cap_a1));
    check_reg(REG_CAP_LANE, 32'(cap_sel));
    drive_capture(40, 1'b0);
    apb_write(REG_CTRL, 32'h4);
    check_reg(REG_CTRL, 32'h4);
    drive_capture(120, 1'b1);
    apb_write(REG_CTRL, 32'h0);
    drive_capture(40, 1'b0);
    report_test(4, "lane captures");
  endtask

  task automatic test_feat_monitor();
    feat_addr_t limit;
    feat_addr_t last;
    dbg_cnt_t   ovf_cnt;
    logic       ena_seen;
    logic       ovf_seen;
    apb_data_t  got;
    check_reg(REG_FEAT_LIMIT, 32'(`DBG_FEAT_LIMIT_RST));
    apb_write(REG_CTRL, 32'h1);
    limit = feat_addr_t'($urandom_range(4096, 61440));
    apb_write(REG_FEAT_LIMIT, 32'(limit));
    check_reg(REG_FEAT_LIMIT, 32'(limit));
    last     = '0;
    ovf_cnt  = '0;
    ena_seen = 1'b0;
    ovf_seen = 1'b0;
    repeat (150) begin
      @(negedge clk);
      feat_ena  = 1'($urandom_range(0, 1));
      feat_addr = feat_addr_t'($urandom);
      if (feat_ena) begin
        ena_seen = 1'b1;
        if (feat_addr >= limit) begin
          ovf_seen = 1'b1;
          ovf_cnt  = ovf_cnt + 1;
          last     = feat_addr;
        end
      end
    end
    @(negedge clk);
    feat_ena = 1'b0;
    check_reg(REG_FEAT_OVF_CNT, ovf_cnt);
    check_reg(REG_FEAT_OVF_ADDR, 32'(last));
    apb_xfer(1'b0, REG_FLAGS, '0, 1'b0, got);
    check_value("REG_FLAGS[9:8]", 32'(got[9:8]), 32'({ovf_seen, ena_seen}));
    apb_write(REG_CTRL, 32'h1);
    check_reg(REG_FEAT_OVF_CNT, '0);
    check_reg(REG_FEAT_OVF_ADDR, '0);
    check_reg(REG_FLAGS, '0);
    report_test(5, "feature monitor");
  endtask

  initial begin : watchdog
    #(test_cycles * 2 * clk_period);
    $display("Timeout after %0d ns, the tests did not reach the end",
             test_cycles * 2 * clk_period);
    $display("Checks failed");
    $finish;
  end

  initial begin
    errors        = 0;
    checks        = 0;
    test_err_base = 0;
    void'($urandom(32'hc44d_cae5));
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    expect_err = 1'b0;
    set_stages('0, '0);
    wh_addr    = '0;
    sppe       = '0;
    feat_addr  = '0;
    feat_ena   = 1'b0;
    @(posedge rst_n);
    test_reset_values();
    test_sticky_flags();
    test_counters();
    test_captures();
    test_feat_monitor();
    $display("Summary: 5 tests, %0d value checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam real half_period = 10.0;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  // Reset covers three full clock periods and lifts on a falling edge.
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- gat_debug_top.sv
`timescale 1ns/10ps

module gat_debug_top
  import dbg_pkg::*;
  import dbg_apb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  apb_addr_t  paddr_i,
  input  apb_data_t  pwdata_i,
  output apb_data_t  prdata_o,
  output logic       pready_o,
  output logic       pslverr_o,
  input  logic       spmm_vld_i,
  input  logic       spmm_rdy_i,
  input  logic       dmvm_vld_i,
  input  logic       dmvm_rdy_i,
  input  logic       sm_vld_i,
  input  logic       sm_rdy_i,
  input  logic       aggr_vld_i,
  input  logic       aggr_rdy_i,
  input  wh_addr_t   wh_bram_addr_i,
  input  sppe_bus_t  sppe_i,
  input  feat_addr_t feat_bram_addr_i,
  input  logic       feat_bram_ena_i
);

  stage_flags_t vld;
  stage_flags_t rdy;
  stage_flags_t vld_flags;
  stage_flags_t rdy_flags;
  logic         flag_clr;
  logic         cnt_clr;
  logic         cap_en;
  wh_addr_t     cap_addr0;
  wh_addr_t     cap_addr1;
  lane_sel_t    cap_lane;
  feat_addr_t   feat_limit;
  dbg_cnt_t     cnt0;
  dbg_cnt_t     cnt1;
  dbg_cnt_t     cnt2;
  dbg_cnt_t     cnt3;
  lane_data_t   cap_data0;
  lane_data_t   cap_data1;
  logic         feat_ena_seen;
  logic         feat_ovf_seen;
  dbg_cnt_t     feat_ovf_cnt;
  feat_addr_t   feat_ovf_addr;

  // Pipeline order from the top bit down: SpMM, DMVM, softmax, aggregation.
  assign vld = {spmm_vld_i, dmvm_vld_i, sm_vld_i, aggr_vld_i};
  assign rdy = {spmm_rdy_i, dmvm_rdy_i, sm_rdy_i, aggr_rdy_i};

  dbg_ctrl i_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .flag_clr_o      (flag_clr),
    .cnt_clr_o       (cnt_clr),
    .cap_en_o        (cap_en),
    .cap_addr0_o     (cap_addr0),
    .cap_addr1_o     (cap_addr1),
    .cap_lane_o      (cap_lane),
    .feat_limit_o    (feat_limit),
    .vld_flags_i     (vld_flags),
    .rdy_flags_i     (rdy_flags),
    .cnt0_i          (cnt0),
    .cnt1_i          (cnt1),
    .cnt2_i          (cnt2),
    .cnt3_i          (cnt3),
    .cap_data0_i     (cap_data0),
    .cap_data1_i     (cap_data1),
    .feat_ena_seen_i (feat_ena_seen),
    .feat_ovf_seen_i (feat_ovf_seen),
    .feat_ovf_cnt_i  (feat_ovf_cnt),
    .feat_ovf_addr_i (feat_ovf_addr)
  );

  stage_flag_tracker i_flags (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr_i       (flag_clr),
    .vld_i       (vld),
    .rdy_i       (rdy),
    .vld_flags_o (vld_flags),
    .rdy_flags_o (rdy_flags)
  );

  stage_event_counter i_counter (
    .clk    (clk),
    .rst_n  (rst_n),
    .clr_i  (cnt_clr),
    .vld_i  (vld),
    .rdy_i  (rdy),
    .cnt0_o (cnt0),
    .cnt1_o (cnt1),
    .cnt2_o (cnt2),
    .cnt3_o (cnt3)
  );

  sppe_capture i_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .en_i       (cap_en),
    .addr0_i    (cap_addr0),
    .addr1_i    (cap_addr1),
    .lane_i     (cap_lane),
    .wh_addr_i  (wh_bram_addr_i),
    .spmm_rdy_i (spmm_rdy_i),
    .sppe_i     (sppe_i),
    .data0_o    (cap_data0),
    .data1_o    (cap_data1)
  );

  feat_write_monitor i_feat_mon (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr_i       (flag_clr),
    .limit_i     (feat_limit),
    .feat_addr_i (feat_bram_addr_i),
    .feat_ena_i  (feat_bram_ena_i),
    .ena_seen_o  (feat_ena_seen),
    .ovf_seen_o  (feat_ovf_seen),
    .ovf_cnt_o   (feat_ovf_cnt),
    .ovf_addr_o  (feat_ovf_addr)
  );

endmodule

//--- feat_write_monitor.sv
`timescale 1ns/10ps

module feat_write_monitor
  import dbg_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clr_i,
  input  feat_addr_t limit_i,
  input  feat_addr_t feat_addr_i,
  input  logic       feat_ena_i,
  output logic       ena_seen_o,
  output logic       ovf_seen_o,
  output dbg_cnt_t   ovf_cnt_o,
  output feat_addr_t ovf_addr_o
);

  logic ovf;

  // A write past the programmed end of the feature buffer.
  assign ovf = feat_ena_i && (feat_addr_i >= limit_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ena_seen_o <= 1'b0;
      ovf_seen_o <= 1'b0;
      ovf_cnt_o  <= '0;
      ovf_addr_o <= '0;
    end else if (clr_i) begin
      ena_seen_o <= 1'b0;
      ovf_seen_o <= 1'b0;
      ovf_cnt_o  <= '0;
      ovf_addr_o <= '0;
    end else begin
      if (feat_ena_i) begin
        ena_seen_o <= 1'b1;
      end
      if (ovf) begin
        ovf_seen_o <= 1'b1;
        ovf_cnt_o  <= ovf_cnt_o + 1'b1;
        ovf_addr_o <= feat_addr_i;
      end
    end
  end

endmodule

//--- sppe_capture.sv
`timescale 1ns/10ps
`include "gat_debug_config.svh"

module sppe_capture
  import dbg_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       en_i,
  input  wh_addr_t   addr0_i,
  input  wh_addr_t   addr1_i,
  input  lane_sel_t  lane_i,
  input  wh_addr_t   wh_addr_i,
  input  logic       spmm_rdy_i,
  input  sppe_bus_t  sppe_i,
  output lane_data_t data0_o,
  output lane_data_t data1_o
);

  lane_data_t lane_data;
  logic       arm;
  logic       hit0;
  logic       hit1;

  assign lane_data = sppe_i[lane_i*`DBG_LANE_W +: `DBG_LANE_W];

  // A slot only samples while capture is on and SpMM is accepting data.
  assign arm  = en_i && spmm_rdy_i;
  assign hit0 = arm && (wh_addr_i == addr0_i);
  assign hit1 = arm && (wh_addr_i == addr1_i);

  // The slots are independent, so both load when the two addresses are equal.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data0_o <= '0;
      data1_o <= '0;
    end else begin
      if (hit0) begin
        data0_o <= lane_data;
      end
      if (hit1) begin
        data1_o <= lane_data;
      end
    end
  end

endmodule

//--- stage_event_counter.sv
`timescale 1ns/10ps

module stage_event_counter
  import dbg_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         clr_i,
  input  stage_flags_t vld_i,
  input  stage_flags_t rdy_i,
  output dbg_cnt_t     cnt0_o,
  output dbg_cnt_t     cnt1_o,
  output dbg_cnt_t     cnt2_o,
  output dbg_cnt_t     cnt3_o
);

  stage_flags_t xfer;
  dbg_cnt_t     cnt_q [$bits(stage_flags_t)];

  // A handshake completes in any cycle where valid and ready are both high.
  assign xfer = vld_i & rdy_i;

  for (genvar i = 0; i < $bits(stage_flags_t); i++) begin : g_cnt
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q[i] <= '0;
      end else if (clr_i) begin
        cnt_q[i] <= '0;
      end else if (xfer[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  // Counter 0 follows SpMM, which sits in the top bit of the stage vectors.
  assign cnt0_o = cnt_q[3];
  assign cnt1_o = cnt_q[2];
  assign cnt2_o = cnt_q[1];
  assign cnt3_o = cnt_q[0];

endmodule

//--- stage_flag_tracker.sv
`timescale 1ns/10ps

module stage_flag_tracker
  import dbg_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         clr_i,
  input  stage_flags_t vld_i,
  input  stage_flags_t rdy_i,
  output stage_flags_t vld_flags_o,
  output stage_flags_t rdy_flags_o
);

  // Every flag latches the first high cycle of its input and keeps it.
  // A clear in the same cycle as a new event wins.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_flags_o <= '0;
      rdy_flags_o <= '0;
    end else if (clr_i) begin
      vld_flags_o <= '0;
      rdy_flags_o <= '0;
    end else begin
      vld_flags_o <= vld_flags_o | vld_i;
      rdy_flags_o <= rdy_flags_o | rdy_i;
    end
  end

endmodule

//--- dbg_ctrl.sv
`timescale 1ns/10ps
`include "gat_debug_config.svh"

module dbg_ctrl
  import dbg_pkg::*;
  import dbg_apb_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         psel_i,
  input  logic         penable_i,
  input  logic         pwrite_i,
  input  apb_addr_t    paddr_i,
  input  apb_data_t    pwdata_i,
  output apb_data_t    prdata_o,
  output logic         pready_o,
  output logic         pslverr_o,
  output logic         flag_clr_o,
  output logic         cnt_clr_o,
  output logic         cap_en_o,
  output wh_addr_t     cap_addr0_o,
  output wh_addr_t     cap_addr1_o,
  output lane_sel_t    cap_lane_o,
  output feat_addr_t   feat_limit_o,
  input  stage_flags_t vld_flags_i,
  input  stage_flags_t rdy_flags_i,
  input  dbg_cnt_t     cnt0_i,
  input  dbg_cnt_t     cnt1_i,
  input  dbg_cnt_t     cnt2_i,
  input  dbg_cnt_t     cnt3_i,
  input  lane_data_t   cap_data0_i,
  input  lane_data_t   cap_data1_i,
  input  logic         feat_ena_seen_i,
  input  logic         feat_ovf_seen_i,
  input  dbg_cnt_t     feat_ovf_cnt_i,
  input  feat_addr_t   feat_ovf_addr_i
);

  localparam logic [7:0] id_version = 8'h01;

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_e;

  apb_state_e state_q;
  apb_state_e state_d;
  apb_data_t  id_word;
  apb_data_t  rd_data;
  logic       access;
  logic       proto_err;
  logic       reg_mapped;
  logic       reg_ro;
  logic       slverr;
  logic       wr_en;

  always_comb begin
    if (psel_i && !penable_i) begin
      state_d = SETUP;
    end else if (psel_i && penable_i && state_q == SETUP) begin
      state_d = ACCESS;
    end else begin
      state_d = IDLE;
    end
  end

  // An access cycle that did not follow a setup cycle breaks the protocol.
  assign access    = psel_i && penable_i;
  assign proto_err = access && (state_q != SETUP);
  assign id_word   = {id_version, 16'h0000, 8'(`DBG_NUM_SPARSE)};

  always_comb begin
    reg_mapped = 1'b1;
    reg_ro     = 1'b1;
    rd_data    = '0;
    case (paddr_i)
      REG_ID:            rd_data = id_word;
      REG_FLAGS: begin
        rd_data = apb_data_t'({feat_ovf_seen_i, feat_ena_seen_i, vld_flags_i, rdy_flags_i});
      end
      REG_CNT0:          rd_data = cnt0_i;
      REG_CNT1:          rd_data = cnt1_i;
      REG_CNT2:          rd_data = cnt2_i;
      REG_CNT3:          rd_data = cnt3_i;
      REG_CAP_DATA0:     rd_data = apb_data_t'(cap_data0_i);
      REG_CAP_DATA1:     rd_data = apb_data_t'(cap_data1_i);
      REG_FEAT_OVF_CNT:  rd_data = feat_ovf_cnt_i;
      REG_FEAT_OVF_ADDR: rd_data = apb_data_t'(feat_ovf_addr_i);
      REG_CTRL: begin
        // The clear bits are pulses and always read back as zero.
        reg_ro  = 1'b0;
        rd_data = apb_data_t'({cap_en_o, 2'b00});
      end
      REG_CAP_ADDR0: begin
        reg_ro  = 1'b0;
        rd_data = apb_data_t'(cap_addr0_o);
      end
      REG_CAP_ADDR1: begin
        reg_ro  = 1'b0;
        rd_data = apb_data_t'(cap_addr1_o);
      end
      REG_CAP_LANE: begin
        reg_ro  = 1'b0;
        rd_data = apb_data_t'(cap_lane_o);
      end
      REG_FEAT_LIMIT: begin
        reg_ro  = 1'b0;
        rd_data = apb_data_t'(feat_limit_o);
      end
      default: reg_mapped = 1'b0;
    endcase
  end

  assign slverr    = !reg_mapped || (pwrite_i && reg_ro) || proto_err;
  assign wr_en     = access && pwrite_i && !slverr;
  assign pready_o  = access;
  assign pslverr_o = access && slverr;
  assign prdata_o  = rd_data;

  // Clear pulses act at the same edge that completes the write.
  assign flag_clr_o = wr_en && (paddr_i == REG_CTRL) && pwdata_i[0];
  assign cnt_clr_o  = wr_en && (paddr_i == REG_CTRL) && pwdata_i[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      cap_en_o     <= 1'b0;
      cap_addr0_o  <= '0;
      cap_addr1_o  <= '0;
      cap_lane_o   <= '0;
      feat_limit_o <= feat_addr_t'(`DBG_FEAT_LIMIT_RST);
    end else begin
      state_q <= state_d;
      if (wr_en) begin
        case (paddr_i)
          REG_CTRL:       cap_en_o     <= pwdata_i[2];
          REG_CAP_ADDR0:  cap_addr0_o  <= pwdata_i[$bits(wh_addr_t)-1:0];
          REG_CAP_ADDR1:  cap_addr1_o  <= pwdata_i[$bits(wh_addr_t)-1:0];
          REG_CAP_LANE:   cap_lane_o   <= pwdata_i[$bits(lane_sel_t)-1:0];
          REG_FEAT_LIMIT: feat_limit_o <= pwdata_i[$bits(feat_addr_t)-1:0];
          default: ;
        endcase
      end
    end
  end

endmodule

//--- dbg_apb_pkg.sv
package dbg_apb_pkg;

  typedef logic [7:0] apb_addr_t;

  typedef logic [31:0] apb_data_t;

  // Byte offsets of the debug registers. Any other offset is an error.
  typedef enum apb_addr_t {
    REG_ID            = 8'h00,
    REG_CTRL          = 8'h04,
    REG_FLAGS         = 8'h08,
    REG_CNT0          = 8'h0C,
    REG_CNT1          = 8'h10,
    REG_CNT2          = 8'h14,
    REG_CNT3          = 8'h18,
    REG_CAP_ADDR0     = 8'h1C,
    REG_CAP_ADDR1     = 8'h20,
    REG_CAP_LANE      = 8'h24,
    REG_CAP_DATA0     = 8'h28,
    REG_CAP_DATA1     = 8'h2C,
    REG_FEAT_LIMIT    = 8'h30,
    REG_FEAT_OVF_CNT  = 8'h34,
    REG_FEAT_OVF_ADDR = 8'h38
  } dbg_reg_e;

endpackage

//--- dbg_pkg.sv
`include "gat_debug_config.svh"

package dbg_pkg;

  // One bit per stage, SpMM in the top bit down to aggregation in bit 0.
  typedef logic [`DBG_NUM_STAGES-1:0] stage_flags_t;

  // A single processing-element result.
  typedef logic [`DBG_LANE_W-1:0] lane_data_t;

  // All lanes side by side, lane 0 in the low bits.
  typedef logic [`DBG_NUM_LANES*`DBG_LANE_W-1:0] sppe_bus_t;

  typedef logic [$clog2(`DBG_NUM_LANES)-1:0] lane_sel_t;

  typedef logic [`DBG_WH_ADDR_W-1:0] wh_addr_t;

  typedef logic [`DBG_FEAT_ADDR_W-1:0] feat_addr_t;

  typedef logic [`DBG_CNT_W-1:0] dbg_cnt_t;

endpackage

//--- gat_debug_config.svh
`ifndef GAT_DEBUG_CONFIG_SVH
`define GAT_DEBUG_CONFIG_SVH

// Stages of the observed pipeline: SpMM, DMVM, softmax and aggregation.
`define DBG_NUM_STAGES 4

// Sparse processing-element lanes and the width of one lane result.
`define DBG_NUM_LANES 16
`define DBG_LANE_W 12

// Weight-buffer read address and feature-buffer write address widths.
`define DBG_WH_ADDR_W 14
`define DBG_FEAT_ADDR_W 16

// All event counters share this width and wrap at the top.
`define DBG_CNT_W 32

// Sparse data per row, reported in the low byte of the ID register.
`define DBG_NUM_SPARSE 12

// Feature writes at or above this address count as overflow after reset.
`define DBG_FEAT_LIMIT_RST 43328

`endif
